//--- hdl/exec_cluster_params.svh
`ifndef EXEC_CLUSTER_PARAMS_SVH
`define EXEC_CLUSTER_PARAMS_SVH

// Datapath widths
`define EXC_DATA_WIDTH 32
`define EXC_REG_BITS 4
`define EXC_IMM_WIDTH 16

// Issue queue entries, also the sender's credits after reset
`define EXC_QUEUE_DEPTH 4

// Multiply latency from issue to writeback
`define EXC_MUL_STAGES 5

`endif

//--- hdl/exec_cluster_pkg.sv
`default_nettype none
`include "exec_cluster_params.svh"

package exec_cluster_pkg;

  typedef enum logic [1:0] {
    OP_LI  = 2'd0,  // rd = zero-extended imm
    OP_ADD = 2'd1,  // rd = rs1 + rs2
    OP_MUL = 2'd2   // rd = rs1 * rs2, low half
  } op_e;

  typedef struct packed {
    op_e                        op;
    logic [`EXC_REG_BITS-1:0]   rd;
    logic [`EXC_REG_BITS-1:0]   rs1;
    logic [`EXC_REG_BITS-1:0]   rs2;
    logic [`EXC_IMM_WIDTH-1:0]  imm;
  } issue_t;

  // One writeback per cycle at most
  typedef struct packed {
    logic                       valid;
    logic [`EXC_REG_BITS-1:0]   rd;
    logic [`EXC_DATA_WIDTH-1:0] data;
  } wb_t;

endpackage : exec_cluster_pkg

`default_nettype wire

//--- hdl/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_cluster_params.svh"

module issue_queue (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     push_i,
  input  var exec_cluster_pkg::issue_t entry_i,
  input  logic                     pop_i,
  output logic                     head_valid_o,
  output exec_cluster_pkg::issue_t head_o,
  output logic                     credit_o
);

  localparam int DEPTH    = `EXC_QUEUE_DEPTH;
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  exec_cluster_pkg::issue_t mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                full;

  // Wraps explicitly so any depth works
  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full         = (count == CNT_BITS'(DEPTH));
  assign head_valid_o = (count != '0);
  assign head_o       = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr] <= entry_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_o <= 1'b0;
    end else begin
      credit_o <= pop_i;  // One credit back per freed entry
      if (push_i) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_i) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Sender must respect its credits
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_i)
    push_i |-> !full)
    else $error("issue_queue: push while full");

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_i)
    pop_i |-> head_valid_o)
    else $error("issue_queue: pop while empty");

endmodule : issue_queue

`default_nettype wire

//--- hdl/issue_control.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_cluster_params.svh"

module issue_control (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     head_valid_i,
  input  var exec_cluster_pkg::issue_t head_i,
  input  logic                     mul_wb_next_i,
  input  var exec_cluster_pkg::wb_t wb_i,
  output logic                     pop_o,
  output logic                     mul_valid_o,
  output logic                     alu_valid_o,
  output logic [`EXC_REG_BITS-1:0] rs1_o,
  output logic [`EXC_REG_BITS-1:0] rs2_o,
  output logic [`EXC_REG_BITS-1:0] rd_o
);

  localparam int NUM_REGS = 1 << `EXC_REG_BITS;

  logic [NUM_REGS-1:0] pending;  // Register has a result in flight
  logic                is_mul;
  logic                reg_busy;
  logic                slot_busy;
  logic                issue;

  assign rs1_o = head_i.rs1;
  assign rs2_o = head_i.rs2;
  assign rd_o  = head_i.rd;

  assign is_mul = (head_i.op == exec_cluster_pkg::OP_MUL);

  // RAW on sources and WAW on destination
  assign reg_busy = pending[head_i.rs1] | pending[head_i.rs2] | pending[head_i.rd];

  // ALU result would land on the multiply writeback
  assign slot_busy = !is_mul && mul_wb_next_i;

  assign issue       = head_valid_i && !reg_busy && !slot_busy;
  assign pop_o       = issue;
  assign mul_valid_o = issue && is_mul;
  assign alu_valid_o = issue && !is_mul;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pending <= '0;
    end else begin
      if (wb_i.valid) begin
        pending[wb_i.rd] <= 1'b0;
      end
      if (issue) begin
        pending[head_i.rd] <= 1'b1;
      end
    end
  end

  // The cycle after an ALU issue belongs to the ALU result alone
  a_wb_slot_free: assert property (@(posedge clk_i) disable iff (!rst_i)
    $past(alu_valid_o) |-> (wb_i.valid && (wb_i.rd == $past(head_i.rd))))
    else $error("issue_control: ALU writeback slot taken by another result");

  // Every writeback retires a register this block marked busy
  a_wb_was_pending: assert property (@(posedge clk_i) disable iff (!rst_i)
    wb_i.valid |-> pending[wb_i.rd])
    else $error("issue_control: writeback to register with no result pending");

endmodule : issue_control

`default_nettype wire

//--- hdl/register_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_cluster_params.svh"

module register_file (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [`EXC_REG_BITS-1:0]   rs1_i,
  input  logic [`EXC_REG_BITS-1:0]   rs2_i,
  output logic [`EXC_DATA_WIDTH-1:0] rd1_o,
  output logic [`EXC_DATA_WIDTH-1:0] rd2_o,
  input  var exec_cluster_pkg::wb_t  wb_i
);

  localparam int NUM_REGS = 1 << `EXC_REG_BITS;

  logic [`EXC_DATA_WIDTH-1:0] regs [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.valid) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // No bypass, dependents wait one cycle past writeback
  assign rd1_o = regs[rs1_i];
  assign rd2_o = regs[rs2_i];

endmodule : register_file

`default_nettype wire

//--- hdl/mul_pipe.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_cluster_params.svh"

module mul_pipe #(
  parameter int STAGES = `EXC_MUL_STAGES
)(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  input  logic [`EXC_REG_BITS-1:0]   wr_reg_i,
  input  logic [`EXC_DATA_WIDTH-1:0] a_i,
  input  logic [`EXC_DATA_WIDTH-1:0] b_i,
  output logic                       wb_is_next_cycle_o,
  output logic                       result_ready_o,
  output logic [`EXC_REG_BITS-1:0]   wr_reg_o,
  output logic [`EXC_DATA_WIDTH-1:0] result_o
);

  // Internal stages, the output register is the last one
  localparam int INNER = STAGES - 1;

  logic [INNER-1:0]           valid_q;
  logic [`EXC_REG_BITS-1:0]   tag_q  [INNER];
  logic [`EXC_DATA_WIDTH-1:0] prod_q [INNER];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q        <= '0;
      result_ready_o <= 1'b0;
    end else begin
      valid_q[0] <= valid_i;
      for (int i = 1; i < INNER; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
      result_ready_o <= valid_q[INNER-1];
    end
  end

  always_ff @(posedge clk_i) begin
    tag_q[0]  <= wr_reg_i;
    prod_q[0] <= a_i * b_i;  // Low half of the product
    for (int i = 1; i < INNER; i++) begin
      tag_q[i]  <= tag_q[i-1];
      prod_q[i] <= prod_q[i-1];
    end
    wr_reg_o <= tag_q[INNER-1];
    result_o <= prod_q[INNER-1];
  end

  // Lets issue control keep the ALU off this writeback slot
  assign wb_is_next_cycle_o = valid_q[INNER-1];

endmodule : mul_pipe

`default_nettype wire

//--- hdl/exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_cluster_params.svh"

module exec_cluster (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     issue_valid_i,
  input  var exec_cluster_pkg::issue_t issue_i,
  output logic                     credit_o,
  output exec_cluster_pkg::wb_t    wb_o
);

  localparam int DW = `EXC_DATA_WIDTH;
  localparam int RB = `EXC_REG_BITS;

  exec_cluster_pkg::issue_t head;
  exec_cluster_pkg::wb_t    alu_wb;
  exec_cluster_pkg::wb_t    wb;

  logic          head_valid;
  logic          pop;
  logic          mul_valid;
  logic          alu_valid;
  logic          mul_wb_next;
  logic          mul_ready;
  logic [RB-1:0] rs1;
  logic [RB-1:0] rs2;
  logic [RB-1:0] rd;
  logic [RB-1:0] mul_rd;
  logic [DW-1:0] rd1;
  logic [DW-1:0] rd2;
  logic [DW-1:0] mul_result;
  logic [DW-1:0] alu_result;

  issue_queue i_queue (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_i       (issue_valid_i),
    .entry_i      (issue_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_o       (head),
    .credit_o     (credit_o)
  );

  issue_control i_control (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .head_valid_i  (head_valid),
    .head_i        (head),
    .mul_wb_next_i (mul_wb_next),
    .wb_i          (wb),
    .pop_o         (pop),
    .mul_valid_o   (mul_valid),
    .alu_valid_o   (alu_valid),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .rd_o          (rd)
  );

  register_file i_regs (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .rs1_i (rs1),
    .rs2_i (rs2),
    .rd1_o (rd1),
    .rd2_o (rd2),
    .wb_i  (wb)
  );

  mul_pipe #(.STAGES(`EXC_MUL_STAGES)) i_mul (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .valid_i            (mul_valid),
    .wr_reg_i           (rd),
    .a_i                (rd1),
    .b_i                (rd2),
    .wb_is_next_cycle_o (mul_wb_next),
    .result_ready_o     (mul_ready),
    .wr_reg_o           (mul_rd),
    .result_o           (mul_result)
  );

  assign alu_result = (head.op == exec_cluster_pkg::OP_LI) ? DW'(head.imm) : rd1 + rd2;

  // Single-cycle ALU stage
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      alu_wb.valid <= 1'b0;
    end else begin
      alu_wb.valid <= alu_valid;
    end
    if (alu_valid) begin
      alu_wb.rd   <= rd;
      alu_wb.data <= alu_result;
    end
  end

  // Issue control keeps the two sources apart
  always_comb begin
    wb = alu_wb;
    if (mul_ready) begin
      wb.valid = 1'b1;
      wb.rd    = mul_rd;
      wb.data  = mul_result;
    end
  end

  assign wb_o = wb;

  a_single_writeback: assert property (@(posedge clk_i) disable iff (!rst_i)
    !(alu_wb.valid && mul_ready))
    else $error("exec_cluster: ALU and multiply writeback in the same cycle");

endmodule : exec_cluster

`default_nettype wire

//--- verification/exec_cluster_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_cluster_params.svh"

module exec_cluster_tb;

  localparam int DW         = `EXC_DATA_WIDTH;
  localparam int RB         = `EXC_REG_BITS;
  localparam int IW         = `EXC_IMM_WIDTH;
  localparam int NUM_REGS   = 1 << RB;
  localparam int DEPTH      = `EXC_QUEUE_DEPTH;
  localparam int WAIT_LIMIT = 300;

  typedef struct packed {
    logic [RB-1:0] rd;
    logic [DW-1:0] data;
  } expect_t;

  logic                     clk_i;
  logic                     rst_i;
  logic                     issue_valid_i;
  exec_cluster_pkg::issue_t issue_i;
  logic                     credit_o;
  exec_cluster_pkg::wb_t    wb_o;

  logic [31:0]   lfsr_state;
  logic [DW-1:0] model_regs [NUM_REGS];
  expect_t       exp_hist [$];   // Expected results in send order
  int            sent_count;
  int            wb_count;
  int            credits_returned;
  int            rd_wb_cnt [NUM_REGS];  // Writebacks seen per register

  logic          chk_wb_valid;
  logic          chk_have;
  logic          chk_credit;
  logic [RB-1:0] chk_rd;
  logic [DW-1:0] chk_got;
  logic [DW-1:0] chk_exp;

  exec_cluster i_dut (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .issue_i       (issue_i),
    .credit_o      (credit_o),
    .wb_o          (wb_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "Stopping at first failure");
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  function automatic exec_cluster_pkg::issue_t make_instr(input exec_cluster_pkg::op_e op,
      input int rd, input int rs1, input int rs2, input logic [31:0] imm);
    exec_cluster_pkg::issue_t ins;
    ins.op  = op;
    ins.rd  = RB'(rd);
    ins.rs1 = RB'(rs1);
    ins.rs2 = RB'(rs2);
    ins.imm = imm[IW-1:0];
    return ins;
  endfunction

  // Program-order result from the model registers
  function automatic logic [DW-1:0] expected_result(input exec_cluster_pkg::issue_t ins);
    logic [2*DW-1:0] wide;
    case (ins.op)
      exec_cluster_pkg::OP_LI:  wide = {{(2*DW-IW){1'b0}}, ins.imm};
      exec_cluster_pkg::OP_ADD: wide = (2*DW)'(model_regs[ins.rs1]) + (2*DW)'(model_regs[ins.rs2]);
      default:                  wide = (2*DW)'(model_regs[ins.rs1]) * (2*DW)'(model_regs[ins.rs2]);
    endcase
    return wide[DW-1:0];
  endfunction

  task automatic idle(input int n);
    issue_valid_i = 1'b0;
    repeat (n) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic send(input exec_cluster_pkg::issue_t ins);
    int      guard;
    expect_t rec;
    guard = 0;
    while (DEPTH - sent_count + credits_returned == 0) begin  // Out of credits
      issue_valid_i = 1'b0;
      @(posedge clk_i);
      #2;
      guard++;
      if (guard > WAIT_LIMIT) begin
        fail_run("Timeout: sender never got a credit back");
      end
    end
    rec.rd   = ins.rd;
    rec.data = expected_result(ins);
    exp_hist.push_back(rec);
    model_regs[ins.rd] = rec.data;
    sent_count++;
    issue_i       = ins;
    issue_valid_i = 1'b1;
    @(posedge clk_i);
    #2;
    issue_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int guard;
    guard = 0;
    while (wb_count != sent_count || credits_returned != sent_count) begin
      @(posedge clk_i);
      #2;
      guard++;
      if (guard > WAIT_LIMIT) begin
        fail_run($sformatf("Timeout: %0d of %0d writebacks and %0d credits seen",
                           wb_count, sent_count, credits_returned));
      end
    end
  endtask

  function automatic int regs_with_leftovers();
    int left;
    int cnt;
    left = 0;
    for (int r = 0; r < NUM_REGS; r++) begin
      cnt = 0;
      for (int i = 0; i < exp_hist.size(); i++) begin
        if (exp_hist[i].rd == RB'(r)) cnt++;
      end
      if (cnt != rd_wb_cnt[r]) left++;
    end
    return left;
  endfunction

  // Outputs are stable mid-cycle, the assertions look at them on the next edge
  always @(negedge clk_i) begin
    int seen;
    chk_wb_valid = 1'b0;
    chk_have     = 1'b0;
    chk_credit   = 1'b0;
    if (!rst_i) begin
      wb_count         = 0;
      credits_returned = 0;
      for (int r = 0; r < NUM_REGS; r++) rd_wb_cnt[r] = 0;
    end else begin
      chk_credit = credit_o;
      if (credit_o) credits_returned++;
      if (wb_o.valid) begin
        chk_wb_valid = 1'b1;
        chk_rd       = wb_o.rd;
        chk_got      = wb_o.data;
        chk_exp      = '0;
        seen         = 0;
        for (int i = 0; i < exp_hist.size(); i++) begin
          if (exp_hist[i].rd == wb_o.rd) begin
            if (seen == rd_wb_cnt[wb_o.rd]) begin  // Oldest not yet written for this rd
              chk_have = 1'b1;
              chk_exp  = exp_hist[i].data;
            end
            seen++;
          end
        end
        rd_wb_cnt[wb_o.rd]++;
        wb_count++;
      end
    end
  end

  a_quiet_before_send: assert property (@(posedge clk_i) disable iff (!rst_i)
    (sent_count == 0) |-> (!chk_wb_valid && !chk_credit))
    else fail_run($sformatf("Mismatch at %0t: wb_o.valid/credit_o got %0b/%0b expected 0/0",
                            $time, chk_wb_valid, chk_credit));

  a_wb_expected: assert property (@(posedge clk_i) disable iff (!rst_i)
    chk_wb_valid |-> chk_have)
    else fail_run($sformatf("Writeback to r%0d at %0t has no instruction waiting for it",
                            chk_rd, $time));

  a_wb_data: assert property (@(posedge clk_i) disable iff (!rst_i)
    (chk_wb_valid && chk_have) |-> (chk_got == chk_exp))
    else fail_run($sformatf("Mismatch at %0t: wb_o.data (r%0d) got 0x%08h expected 0x%08h",
                            $time, chk_rd, chk_got, chk_exp));

  a_credit_count: assert property (@(posedge clk_i) disable iff (!rst_i)
    chk_credit |-> (credits_returned <= sent_count))
    else fail_run($sformatf("Mismatch at %0t: credit_o count got %0d expected at most %0d",
                            $time, credits_returned, sent_count));

  initial begin
    int prev;
    int sel;
    int rd;
    int rs1;
    int rs2;
    int burst;
    rst_i         = 1'b0;
    issue_valid_i = 1'b0;
    issue_i       = '0;
    sent_count    = 0;
    lfsr_state    = 32'h5c05;
    for (int r = 0; r < NUM_REGS; r++) model_regs[r] = '0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_i = 1'b1;
    idle(3);

    // WAW on r1 parks the load behind the multiply so the queue fills
    send(make_instr(exec_cluster_pkg::OP_MUL, 1, 0, 0, 0));
    send(make_instr(exec_cluster_pkg::OP_LI, 1, 0, 0, 32'h0000_beef));
    for (int i = 2; i <= 6; i++) send(make_instr(exec_cluster_pkg::OP_LI, i, 0, 0, rand_bits(16)));
    wait_drain();

    send(make_instr(exec_cluster_pkg::OP_LI, 3, 0, 0, 32'h0000_ffff));
    send(make_instr(exec_cluster_pkg::OP_ADD, 5, 1, 2, 0));
    send(make_instr(exec_cluster_pkg::OP_MUL, 6, 3, 4, 0));
    send(make_instr(exec_cluster_pkg::OP_MUL, 7, 6, 6, 0));   // Product wraps
    send(make_instr(exec_cluster_pkg::OP_ADD, 8, 7, 7, 0));
    send(make_instr(exec_cluster_pkg::OP_ADD, 9, 7, 6, 0));
    wait_drain();

    // Dependent chain
    prev = 5;
    for (int i = 0; i < 8; i++) begin
      rs2 = 1 + rand_bits(2);
      send(make_instr((i % 2 == 0) ? exec_cluster_pkg::OP_MUL : exec_cluster_pkg::OP_ADD,
                      8 + i, prev, rs2, 0));
      prev = 8 + i;
    end
    wait_drain();

    // Bursts of mostly independent work, sources r0..r7, destinations r8..r15
    for (int b = 0; b < 14; b++) begin
      burst = 1 + rand_bits(3);
      for (int k = 0; k < burst; k++) begin
        sel = rand_bits(2);
        rd  = 8 + rand_bits(3);
        rs1 = rand_bits(3);
        rs2 = rand_bits(3);
        if (sel == 0) send(make_instr(exec_cluster_pkg::OP_LI, rd, 0, 0, rand_bits(16)));
        else if (sel == 1) send(make_instr(exec_cluster_pkg::OP_ADD, rd, rs1, rs2, 0));
        else send(make_instr(exec_cluster_pkg::OP_MUL, rd, rs1, rs2, 0));
      end
      idle(rand_bits(2));
    end
    wait_drain();
    idle(2 * `EXC_MUL_STAGES);

    if (credits_returned != sent_count) begin
      fail_run($sformatf("Mismatch at %0t: credit_o count got %0d expected %0d",
                         $time, credits_returned, sent_count));
    end else if (regs_with_leftovers() != 0) begin
      fail_run("Expected writebacks are still outstanding after the drain");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule : exec_cluster_tb

`default_nettype wire

//--- exec_cluster.f
+incdir+hdl
hdl/exec_cluster_pkg.sv
hdl/issue_queue.sv
hdl/issue_control.sv
hdl/register_file.sv
hdl/mul_pipe.sv
hdl/exec_cluster.sv
verification/exec_cluster_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds exec_cluster_tb with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert \
  --top-module exec_cluster_tb \
  --Mdir obj_dir \
  -o exec_cluster_tb_sim \
  -f exec_cluster.f \
  && ./obj_dir/exec_cluster_tb_sim > "$LOG" 2>&1 \
  || echo "Build or simulation returned an error"

cat "$LOG" 2>/dev/null

[ -s "$LOG" ] || { echo "FAIL: no simulation log"; exit 1; }
grep -q "Test failures found" "$LOG" && { echo "FAIL"; exit 1; }
echo "PASS"
exit 0
